// File: source/dcache_pkg.sv
// Shared enums for the split data cache; privilege values follow the RISC-V privilege encoding
package dcache_pkg;

  // Privilege level carried with every request
  typedef enum logic [1:0] {
    PRIV_U = 2'd0, // User
    PRIV_S = 2'd1, // Supervisor
    PRIV_M = 2'd3  // Machine, served by the direct controller
  } priv_lvl_e;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Request sequence inside each controller
  //   ST_IDLE  waiting for a request
  //   ST_MEM   asking the arbiter for the line memory
  //   ST_RESP  presenting the response until it is taken
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_MEM  = 2'd1,
    ST_RESP = 2'd2
  } ctrl_state_e;

  // Valid array clear sequence in the tagged controller
  typedef enum logic {
    FL_IDLE  = 1'b0, // Valid bits are live
    FL_CLEAR = 1'b1  // Clear in progress, lookups see all lines invalid
  } flush_state_e;

  // A flush pulse arrives with the accepted request that changed privilege.
  // The ordering guard keeps any second request out for at least two
  // cycles, so FL_CLEAR never lasts longer than one cycle.

  // The memory is split by its address MSB
  //   0  machine region, indexed by the full index
  //   1  dual region, indexed by the low dual index bits only

endpackage

// File: source/dcache_top.sv
// Top level of the split data cache; no next-level memory, tagged read misses return zero data
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
#(
  parameter int unsigned ADDR_WIDTH       = 32,
  parameter int unsigned LINE_WIDTH       = 64,
  parameter int unsigned OFFSET_WIDTH     = 3,
  parameter int unsigned INDEX_WIDTH      = 4,
  parameter int unsigned DUAL_INDEX_WIDTH = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  priv_lvl_e             req_priv_i,
  input  op_e                   req_op_i,
  input  logic [ADDR_WIDTH-1:0] req_addr_i,
  input  logic [LINE_WIDTH-1:0] req_wdata_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output logic [LINE_WIDTH-1:0] rsp_rdata_o,
  output logic                  rsp_hit_o
);

  localparam int unsigned MEM_AW = INDEX_WIDTH + 1; // Region bit on top of the index

  logic                  m_valid, m_ready, m_busy;
  logic                  u_valid, u_ready, u_busy;
  logic                  flush;

  logic                  m_mem_req, m_mem_gnt, m_mem_we;
  logic [MEM_AW-1:0]     m_mem_addr;
  logic [LINE_WIDTH-1:0] m_mem_wdata;
  logic                  u_mem_req, u_mem_gnt, u_mem_we;
  logic [MEM_AW-1:0]     u_mem_addr;
  logic [LINE_WIDTH-1:0] u_mem_wdata;

  logic                  mem_en, mem_we;
  logic [MEM_AW-1:0]     mem_addr;
  logic [LINE_WIDTH-1:0] mem_wdata, mem_rdata;

  logic                  m_rsp_valid, u_rsp_valid, u_rsp_hit;
  logic [LINE_WIDTH-1:0] m_rsp_rdata, u_rsp_rdata;

  priv_router i_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_priv_i  (req_priv_i),
    .req_ready_o (req_ready_o),
    .m_valid_o   (m_valid),
    .m_ready_i   (m_ready),
    .m_busy_i    (m_busy),
    .u_valid_o   (u_valid),
    .u_ready_i   (u_ready),
    .u_busy_i    (u_busy),
    .flush_o     (flush)
  );

  direct_port_ctrl #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .LINE_WIDTH   (LINE_WIDTH),
    .OFFSET_WIDTH (OFFSET_WIDTH),
    .INDEX_WIDTH  (INDEX_WIDTH)
  ) i_direct (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .valid_i (m_valid), .ready_o (m_ready), .op_i (req_op_i),
    .addr_i (req_addr_i), .wdata_i (req_wdata_i), .busy_o (m_busy),
    .mem_req_o (m_mem_req), .mem_gnt_i (m_mem_gnt), .mem_we_o (m_mem_we),
    .mem_addr_o (m_mem_addr), .mem_wdata_o (m_mem_wdata), .mem_rdata_i (mem_rdata),
    .rsp_valid_o (m_rsp_valid), .rsp_ready_i (rsp_ready_i), .rsp_rdata_o (m_rsp_rdata)
  );

  tagged_port_ctrl #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .LINE_WIDTH       (LINE_WIDTH),
    .OFFSET_WIDTH     (OFFSET_WIDTH),
    .INDEX_WIDTH      (INDEX_WIDTH),
    .DUAL_INDEX_WIDTH (DUAL_INDEX_WIDTH)
  ) i_tagged (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush),
    .valid_i (u_valid), .ready_o (u_ready), .op_i (req_op_i),
    .addr_i (req_addr_i), .wdata_i (req_wdata_i), .busy_o (u_busy),
    .mem_req_o (u_mem_req), .mem_gnt_i (u_mem_gnt), .mem_we_o (u_mem_we),
    .mem_addr_o (u_mem_addr), .mem_wdata_o (u_mem_wdata), .mem_rdata_i (mem_rdata),
    .rsp_valid_o (u_rsp_valid), .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (u_rsp_rdata), .rsp_hit_o (u_rsp_hit)
  );

  mem_arbiter #(
    .LINE_WIDTH  (LINE_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH)
  ) i_arbiter (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .a_req_i (m_mem_req), .a_gnt_o (m_mem_gnt), .a_we_i (m_mem_we),
    .a_addr_i (m_mem_addr), .a_wdata_i (m_mem_wdata),
    .b_req_i (u_mem_req), .b_gnt_o (u_mem_gnt), .b_we_i (u_mem_we),
    .b_addr_i (u_mem_addr), .b_wdata_i (u_mem_wdata),
    .mem_en_o (mem_en), .mem_we_o (mem_we), .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata)
  );

  line_mem #(
    .LINE_WIDTH  (LINE_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH)
  ) i_line_mem (
    .clk_i (clk_i), .en_i (mem_en), .we_i (mem_we),
    .addr_i (mem_addr), .wdata_i (mem_wdata), .rdata_o (mem_rdata)
  );

  // At most one controller responds at a time
  assign rsp_valid_o = m_rsp_valid | u_rsp_valid;
  assign rsp_rdata_o = m_rsp_valid ? m_rsp_rdata : u_rsp_rdata;
  assign rsp_hit_o   = m_rsp_valid ? 1'b1 : u_rsp_hit; // Machine region always hits

endmodule

// File: source/direct_port_ctrl.sv
// Machine-mode controller; addresses its region by index alone and ignores tag bits
`timescale 1ns/1ps

module direct_port_ctrl
  import dcache_pkg::*;
#(
  parameter int unsigned ADDR_WIDTH   = 32,
  parameter int unsigned LINE_WIDTH   = 64,
  parameter int unsigned OFFSET_WIDTH = 3,
  parameter int unsigned INDEX_WIDTH  = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  op_e                    op_i,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic [LINE_WIDTH-1:0]  wdata_i,
  output logic                   busy_o,
  output logic                   mem_req_o,
  input  logic                   mem_gnt_i,
  output logic                   mem_we_o,
  output logic [INDEX_WIDTH:0]   mem_addr_o,
  output logic [LINE_WIDTH-1:0]  mem_wdata_o,
  input  logic [LINE_WIDTH-1:0]  mem_rdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [LINE_WIDTH-1:0]  rsp_rdata_o
);

  ctrl_state_e            state_q;
  logic                   rd_first_q;  // Memory read data arrives this cycle
  op_e                    op_q;
  logic [INDEX_WIDTH-1:0] idx_q;
  logic [LINE_WIDTH-1:0]  wdata_q;
  logic [LINE_WIDTH-1:0]  rdata_q;
  logic                   accept;

  assign accept  = valid_i & ready_o;
  assign ready_o = (state_q == ST_IDLE);
  assign busy_o  = (state_q != ST_IDLE);

  assign mem_req_o   = (state_q == ST_MEM);
  assign mem_we_o    = (op_q == OP_WRITE);
  assign mem_addr_o  = {1'b0, idx_q}; // Machine region
  assign mem_wdata_o = wdata_q;

  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_rdata_o = rd_first_q ? mem_rdata_i : rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      rd_first_q <= 1'b0;
    end else begin
      rd_first_q <= 1'b0;
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_MEM;
        ST_MEM: begin
          if (mem_gnt_i) begin
            state_q    <= ST_RESP;
            rd_first_q <= (op_q == OP_READ);
          end
        end
        ST_RESP: if (rsp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload and held read data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= op_i;
      idx_q   <= addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
      wdata_q <= wdata_i;
    end
    if (mem_gnt_i && op_q == OP_WRITE) rdata_q <= '0; // Writes answer with zero data
    if (rd_first_q) rdata_q <= mem_rdata_i;            // Keep the line under back-pressure
  end

endmodule

// File: source/line_mem.sv
// Single-port line RAM with registered read; contents are undefined until written
`timescale 1ns/1ps

module line_mem #(
  parameter int unsigned LINE_WIDTH  = 64,
  parameter int unsigned INDEX_WIDTH = 4
) (
  input  logic                  clk_i,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [INDEX_WIDTH:0]  addr_i,
  input  logic [LINE_WIDTH-1:0] wdata_i,
  output logic [LINE_WIDTH-1:0] rdata_o
);

  localparam int unsigned MEM_AW = INDEX_WIDTH + 1;
  localparam int unsigned DEPTH  = 1 << MEM_AW; // Machine region below, dual region above

  logic [LINE_WIDTH-1:0] mem_q [DEPTH];

  // Write lands at the granted edge, read data one cycle later
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: source/mem_arbiter.sv
// Two-way round-robin arbiter; the grant is combinational and valid only in the request cycle
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int unsigned LINE_WIDTH  = 64,
  parameter int unsigned INDEX_WIDTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  a_req_i,
  output logic                  a_gnt_o,
  input  logic                  a_we_i,
  input  logic [INDEX_WIDTH:0]  a_addr_i,
  input  logic [LINE_WIDTH-1:0] a_wdata_i,
  input  logic                  b_req_i,
  output logic                  b_gnt_o,
  input  logic                  b_we_i,
  input  logic [INDEX_WIDTH:0]  b_addr_i,
  input  logic [LINE_WIDTH-1:0] b_wdata_i,
  output logic                  mem_en_o,
  output logic                  mem_we_o,
  output logic [INDEX_WIDTH:0]  mem_addr_o,
  output logic [LINE_WIDTH-1:0] mem_wdata_o
);

  logic prio_b_q; // Side b wins the next tie

  assign a_gnt_o = a_req_i & (~b_req_i | ~prio_b_q);
  assign b_gnt_o = b_req_i & (~a_req_i |  prio_b_q);

  assign mem_en_o    = a_gnt_o | b_gnt_o;
  assign mem_we_o    = b_gnt_o ? b_we_i    : a_we_i & a_gnt_o;
  assign mem_addr_o  = b_gnt_o ? b_addr_i  : a_addr_i;
  assign mem_wdata_o = b_gnt_o ? b_wdata_i : a_wdata_i;

  // Loser of the last grant gets priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_b_q <= 1'b0;
    end else if (a_gnt_o) begin
      prio_b_q <= 1'b1;
    end else if (b_gnt_o) begin
      prio_b_q <= 1'b0;
    end
  end

endmodule

// File: source/priv_router.sv
// Steers requests by privilege; only one controller may hold an outstanding request
`timescale 1ns/1ps

module priv_router
  import dcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  input  priv_lvl_e req_priv_i,
  output logic      req_ready_o,
  output logic      m_valid_o,
  input  logic      m_ready_i,
  input  logic      m_busy_i,
  output logic      u_valid_o,
  input  logic      u_ready_i,
  input  logic      u_busy_i,
  output logic      flush_o
);

  priv_lvl_e last_priv_q;
  logic      to_m;
  logic      m_allow, u_allow;
  logic      accept;

  assign to_m = (req_priv_i == PRIV_M);

  // Ordering guard
  // A controller may take a request only while the other one is idle
  assign m_allow = m_ready_i & ~u_busy_i;
  assign u_allow = u_ready_i & ~m_busy_i;

  assign req_ready_o = to_m ? m_allow : u_allow;

  assign m_valid_o = req_valid_i & to_m & ~u_busy_i;
  assign u_valid_o = req_valid_i & ~to_m & ~m_busy_i;

  assign accept = req_valid_i & req_ready_o;

  // Pulse in the acceptance cycle of a privilege change
  assign flush_o = accept & (req_priv_i != last_priv_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_priv_q <= PRIV_M; // Core leaves reset in machine mode
    end else if (accept) begin
      last_priv_q <= req_priv_i;
    end
  end

endmodule

// File: source/tagged_port_ctrl.sv
// Lower-privilege controller; write-allocate without refill, so a read miss returns zero data
`timescale 1ns/1ps

module tagged_port_ctrl
  import dcache_pkg::*;
#(
  parameter int unsigned ADDR_WIDTH       = 32,
  parameter int unsigned LINE_WIDTH       = 64,
  parameter int unsigned OFFSET_WIDTH     = 3,
  parameter int unsigned INDEX_WIDTH      = 4,
  parameter int unsigned DUAL_INDEX_WIDTH = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  op_e                    op_i,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic [LINE_WIDTH-1:0]  wdata_i,
  output logic                   busy_o,
  output logic                   mem_req_o,
  input  logic                   mem_gnt_i,
  output logic                   mem_we_o,
  output logic [INDEX_WIDTH:0]   mem_addr_o,
  output logic [LINE_WIDTH-1:0]  mem_wdata_o,
  input  logic [LINE_WIDTH-1:0]  mem_rdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [LINE_WIDTH-1:0]  rsp_rdata_o,
  output logic                   rsp_hit_o
);

  localparam int unsigned TAG_WIDTH  = ADDR_WIDTH - OFFSET_WIDTH - DUAL_INDEX_WIDTH;
  localparam int unsigned DUAL_LINES = 1 << DUAL_INDEX_WIDTH;

  ctrl_state_e                 state_q;
  flush_state_e                fl_state_q;
  logic                        rd_first_q;
  logic                        hit_q;
  logic [DUAL_LINES-1:0]       valid_q;
  logic [TAG_WIDTH-1:0]        tag_arr_q [DUAL_LINES];
  op_e                         op_q;
  logic [DUAL_INDEX_WIDTH-1:0] didx_q;
  logic [TAG_WIDTH-1:0]        tag_q;
  logic [LINE_WIDTH-1:0]       wdata_q;
  logic [LINE_WIDTH-1:0]       rdata_q;

  logic [DUAL_INDEX_WIDTH-1:0] didx;
  logic [TAG_WIDTH-1:0]        tag;
  logic                        accept, lookup_hit, read_miss, set_line;

  assign didx = addr_i[OFFSET_WIDTH +: DUAL_INDEX_WIDTH];
  assign tag  = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

  assign accept  = valid_i & ready_o;
  assign ready_o = (state_q == ST_IDLE);
  assign busy_o  = (state_q != ST_IDLE);

  // Lookup sees the array as already cleared during a flush
  assign lookup_hit = valid_q[didx] & ~flush_i & (fl_state_q == FL_IDLE) &
                      (tag_arr_q[didx] == tag);
  assign read_miss  = accept & (op_i == OP_READ) & ~lookup_hit;
  assign set_line   = mem_gnt_i & (op_q == OP_WRITE); // Write-allocate

  assign mem_req_o   = (state_q == ST_MEM);
  assign mem_we_o    = (op_q == OP_WRITE);
  assign mem_addr_o  = {1'b1, INDEX_WIDTH'(didx_q)}; // Dual region
  assign mem_wdata_o = wdata_q;

  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_rdata_o = rd_first_q ? mem_rdata_i : rdata_q;
  assign rsp_hit_o   = hit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      rd_first_q <= 1'b0;
      hit_q      <= 1'b0;
    end else begin
      rd_first_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            hit_q   <= lookup_hit;
            state_q <= read_miss ? ST_RESP : ST_MEM; // Miss skips the memory
          end
        end
        ST_MEM: begin
          if (mem_gnt_i) begin
            state_q    <= ST_RESP;
            rd_first_q <= (op_q == OP_READ);
          end
        end
        ST_RESP: if (rsp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Valid bits and the clear sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fl_state_q <= FL_IDLE;
      valid_q    <= '0;
    end else begin
      fl_state_q <= flush_i ? FL_CLEAR : FL_IDLE;
      if (fl_state_q == FL_CLEAR) valid_q <= '0;
      if (set_line) valid_q[didx_q] <= 1'b1; // A write granted during the clear survives it
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= op_i;
      didx_q  <= didx;
      tag_q   <= tag;
      wdata_q <= wdata_i;
    end
    if (set_line) tag_arr_q[didx_q] <= tag_q;
    if (read_miss || set_line) rdata_q <= '0;
    if (rd_first_q) rdata_q <= mem_rdata_i;
  end

endmodule

// File: test/tb_rand.svh
// Test constants match the dcache_top defaults; the LFSR yields one bit per step
`ifndef TB_RAND_SVH
`define TB_RAND_SVH

localparam int unsigned CLK_PERIOD = 4;            // ns
localparam int unsigned NUM_REQ    = 2000;         // Directed plus random requests
localparam int unsigned WATCHDOG   = NUM_REQ * 20 * CLK_PERIOD;
localparam int unsigned OFFSET_W   = 3;
localparam int unsigned INDEX_W    = 4;
localparam int unsigned DUAL_W     = 3;
localparam int unsigned TAG_W      = 32 - OFFSET_W - DUAL_W;

localparam logic [31:0] LFSR_SEED = 32'h3a6150a3;
localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

// One Galois step, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

`endif

// File: test/tb_dcache.sv
// Random traffic against a two-region model; reads of unwritten machine lines skip the data check
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  `include "tb_rand.svh"

  typedef struct packed {
    priv_lvl_e   priv;
    op_e         op;
    logic [31:0] addr;
    logic [63:0] data;
  } req_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_valid_i, req_ready_o;
  priv_lvl_e   req_priv_i;
  op_e         req_op_i;
  logic [31:0] req_addr_i;
  logic [63:0] req_wdata_i;
  logic        rsp_valid_o, rsp_ready_i, rsp_hit_o;
  logic [63:0] rsp_rdata_o;

  logic [31:0] lfsr_q = LFSR_SEED;
  req_t        dir_q [$];
  int          accepted, issued, rsp_count;

  // Reference model state
  logic [63:0]      m_mem   [1 << INDEX_W];
  bit               m_known [1 << INDEX_W];
  logic [63:0]      u_mem   [1 << DUAL_W];
  bit               u_valid [1 << DUAL_W];
  logic [TAG_W-1:0] u_tag   [1 << DUAL_W];
  priv_lvl_e        last_priv = PRIV_M;
  logic [63:0]      exp_data_q [$];
  bit               exp_hit_q [$];
  bit               exp_known_q [$];
  string            exp_name_q [$];

  dcache_top i_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic req_t random_req();
    req_t r;
    if (rand_bits(1) != 0) r.priv = PRIV_M;
    else r.priv = (rand_bits(1) != 0) ? PRIV_S : PRIV_U;
    r.op   = (rand_bits(1) != 0) ? OP_WRITE : OP_READ;
    r.addr = 32'(rand_bits(7)); // Two tags per dual index
    r.data = rand_bits(64);
    return r;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic fail_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    stop_run($sformatf("error: %s expected %h actual %h", test, exp, act));
  endtask

  // Expected response pushed at acceptance
  task automatic predict(input req_t r);
    logic [INDEX_W-1:0] idx;
    logic [DUAL_W-1:0]  didx;
    logic [TAG_W-1:0]   tag;
    bit                 hit;
    idx  = r.addr[OFFSET_W +: INDEX_W];
    didx = r.addr[OFFSET_W +: DUAL_W];
    tag  = r.addr[31 -: TAG_W];
    if (r.priv != last_priv) begin
      for (int i = 0; i < (1 << DUAL_W); i++) u_valid[i] = 1'b0; // Switch flush
    end
    last_priv = r.priv;
    if (r.priv == PRIV_M) begin
      exp_name_q.push_back(r.op == OP_WRITE ? "machine write" : "machine read");
      exp_hit_q.push_back(1'b1);
      exp_data_q.push_back(r.op == OP_WRITE ? 64'd0 : m_mem[idx]);
      exp_known_q.push_back(r.op == OP_WRITE || m_known[idx]);
      if (r.op == OP_WRITE) begin
        m_mem[idx]   = r.data;
        m_known[idx] = 1'b1;
      end
    end else begin
      hit = u_valid[didx] && (u_tag[didx] == tag);
      exp_name_q.push_back(r.op == OP_WRITE ? "tagged write" : "tagged read");
      exp_hit_q.push_back(hit);
      exp_data_q.push_back((r.op == OP_READ && hit) ? u_mem[didx] : 64'd0);
      exp_known_q.push_back(1'b1);
      if (r.op == OP_WRITE) begin // Write-allocate
        u_valid[didx] = 1'b1;
        u_tag[didx]   = tag;
        u_mem[didx]   = r.data;
      end
    end
  endtask

  // Acceptance and response monitor
  always @(posedge clk_i) begin
    string name;
    bit    idle;
    if (rst_ni) begin
      idle = (exp_hit_q.size() == 0);
      // Ready only while no response is still owed
      assert (req_ready_o === idle)
        else fail_value("request ready", idle, req_ready_o);
      if (req_valid_i && req_ready_o) begin
        predict('{req_priv_i, req_op_i, req_addr_i, req_wdata_i});
      end
      if (rsp_valid_o && rsp_ready_i) begin
        assert (exp_hit_q.size() != 0)
          else stop_run("a response arrived with no request outstanding");
        name = exp_name_q.pop_front();
        assert (rsp_hit_o === exp_hit_q[0])
          else fail_value({name, " hit"}, exp_hit_q[0], rsp_hit_o);
        if (exp_known_q[0]) begin
          assert (rsp_rdata_o === exp_data_q[0])
            else fail_value({name, " data"}, exp_data_q[0], rsp_rdata_o);
        end
        void'(exp_hit_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_known_q.pop_front());
        rsp_count++;
      end
    end
  end

  initial begin
    #(WATCHDOG);
    stop_run($sformatf("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG));
  end

  initial begin
    req_t r;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_priv_i  = PRIV_M;
    req_op_i    = OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b0;
    // Directed opening sequence, then random traffic
    dir_q.push_back('{PRIV_U, OP_READ,  32'h08, 64'd0});  // Miss after reset
    dir_q.push_back('{PRIV_U, OP_WRITE, 32'h08, 64'h1111_2222_3333_4444});
    dir_q.push_back('{PRIV_U, OP_READ,  32'h08, 64'd0});  // Hit
    dir_q.push_back('{PRIV_U, OP_READ,  32'h48, 64'd0});  // Other tag, same dual index
    dir_q.push_back('{PRIV_M, OP_WRITE, 32'h08, 64'h5555_6666_7777_8888});
    dir_q.push_back('{PRIV_M, OP_READ,  32'h08, 64'd0});
    dir_q.push_back('{PRIV_U, OP_READ,  32'h08, 64'd0});  // Flushed by the switch
    dir_q.push_back('{PRIV_U, OP_WRITE, 32'h48, 64'h9999_aaaa_bbbb_cccc});
    dir_q.push_back('{PRIV_M, OP_READ,  32'h08, 64'd0});  // Machine line survives
    dir_q.push_back('{PRIV_S, OP_READ,  32'h48, 64'd0});
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    assert (rsp_valid_o === 1'b0) else fail_value("reset rsp_valid", 64'd0, rsp_valid_o);
    assert (req_ready_o === 1'b1) else fail_value("reset req_ready", 64'd1, req_ready_o);
    while (accepted < NUM_REQ) begin
      @(posedge clk_i);
      rsp_ready_i <= (rand_bits(1) != 0);
      if (req_valid_i && req_ready_o) accepted++;
      if (!req_valid_i || req_ready_o) begin // Payload held until taken
        if (issued < NUM_REQ && rand_bits(2) != 0) begin
          if (dir_q.size() != 0) r = dir_q.pop_front();
          else r = random_req();
          req_valid_i <= 1'b1;
          req_priv_i  <= r.priv;
          req_op_i    <= r.op;
          req_addr_i  <= r.addr;
          req_wdata_i <= r.data;
          issued++;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
    while (rsp_count < NUM_REQ) begin
      @(posedge clk_i);
      rsp_ready_i <= (rand_bits(1) != 0);
    end
    @(negedge clk_i);
    assert (rsp_valid_o === 1'b0) else stop_run("a response appeared after the last request");
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+test
source/dcache_pkg.sv
source/priv_router.sv
source/direct_port_ctrl.sv
source/tagged_port_ctrl.sv
source/mem_arbiter.sv
source/line_mem.sv
source/dcache_top.sv
test/tb_dcache.sv
